/* hw/isa_pkg.sv */
/*
 * architectural definitions
 * data word, register index and the hardwired zero register
 */

package isa_pkg;

    // data word, also used for program counters
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // writes to this register are dropped
    localparam reg_idx_t zero_reg = 5'd0;

endpackage

/* hw/rob_pkg.sv */
/*
 * reorder buffer definitions
 * entry tags and the states of the store handshake
 */

package rob_pkg;

    // wide enough for a 32 entry buffer, smaller buffers use the low bits
    typedef logic [4:0] rob_tag_t;

    // four-phase req/ack exchange for the store at the head
    typedef enum logic [1:0] {
        idle,
        request,
        wait_release,
        done
    } store_state_t;

endpackage

/* hw/reorder_buffer.sv */
/*
 * reorder buffer
 * circular entry window with in-order dispatch, two result buses,
 * dual in-order retirement, squash on a retiring mispredict and halt
 */

`timescale 1ns/100ps

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 dispatch_valid,
    input  isa_pkg::word_t                       dispatch_pc,
    input  isa_pkg::reg_idx_t                    dispatch_dest,
    input  logic                                 dispatch_is_branch,
    input  logic                                 dispatch_pred_taken,
    input  logic                                 dispatch_store,
    input  logic                                 dispatch_halt,
    input  logic                                 cdb0_valid,
    input  rob_pkg::rob_tag_t                    cdb0_tag,
    input  isa_pkg::word_t                       cdb0_value,
    input  logic                                 cdb0_taken,
    input  isa_pkg::word_t                       cdb0_target,
    input  logic                                 cdb1_valid,
    input  rob_pkg::rob_tag_t                    cdb1_tag,
    input  isa_pkg::word_t                       cdb1_value,
    input  logic                                 cdb1_taken,
    input  isa_pkg::word_t                       cdb1_target,
    input  logic                                 store_done,
    output rob_pkg::rob_tag_t                    dispatch_tag,
    output logic                                 rob_full,
    output rob_pkg::rob_tag_t                    head,
    output logic           [rob_depth-1:0]       entry_valid,
    output logic           [rob_depth-1:0]       entry_ready,
    output logic           [rob_depth-1:0]       entry_mispred,
    output isa_pkg::word_t [rob_depth-1:0]       entry_target,
    output logic                                 store_pending,
    output logic                                 squash,
    output isa_pkg::word_t                       squash_pc,
    output logic                                 halt,
    output logic                                 retire0_write,
    output isa_pkg::reg_idx_t                    retire0_dest,
    output isa_pkg::word_t                       retire0_value,
    output logic                                 retire1_write,
    output isa_pkg::reg_idx_t                    retire1_dest,
    output isa_pkg::word_t                       retire1_value
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int idx_bits = $clog2(rob_depth);

    typedef logic [idx_bits-1:0] idx_t;
    typedef logic [idx_bits:0]   count_t;

    idx_t   head_q, head_n, tail_q, tail_n, head_plus1;
    count_t count_q, count_n;

    // per-entry flags
    logic [rob_depth-1:0] valid_q, valid_n, ready_q, ready_n, mispred_q, mispred_n;
    logic [rob_depth-1:0] branch_q, branch_n, pred_q, pred_n;
    logic [rob_depth-1:0] store_q, store_n, halt_q, halt_n;

    // per-entry payload
    word_t    [rob_depth-1:0] pc_q, pc_n, value_q, value_n, target_q, target_n;
    reg_idx_t [rob_depth-1:0] dest_q, dest_n;

    logic empty, accept;
    logic retire0, retire1, squash0, squash1;

    // both buses as one indexable set
    logic     cdb_valid  [2];
    rob_tag_t cdb_tag    [2];
    word_t    cdb_value  [2];
    logic     cdb_taken  [2];
    word_t    cdb_target [2];

    assign cdb_valid[0]  = cdb0_valid;
    assign cdb_tag[0]    = cdb0_tag;
    assign cdb_value[0]  = cdb0_value;
    assign cdb_taken[0]  = cdb0_taken;
    assign cdb_target[0] = cdb0_target;
    assign cdb_valid[1]  = cdb1_valid;
    assign cdb_tag[1]    = cdb1_tag;
    assign cdb_value[1]  = cdb1_value;
    assign cdb_taken[1]  = cdb1_taken;
    assign cdb_target[1] = cdb1_target;

    //////////////////////////////
    // status and retire rules
    //////////////////////////////

    assign head_plus1 = head_q + 1'b1;
    assign empty      = (count_q == '0);
    assign rob_full   = (count_q == count_t'(rob_depth));
    assign accept     = dispatch_valid && !rob_full;

    assign dispatch_tag  = rob_tag_t'(tail_q);
    assign head          = rob_tag_t'(head_q);
    assign entry_valid   = valid_q;
    assign entry_ready   = ready_q;
    assign entry_mispred = mispred_q;
    assign entry_target  = target_q;

    assign store_pending = valid_q[head_q] && ready_q[head_q] && store_q[head_q];
    assign halt          = valid_q[head_q] && halt_q[head_q];

    // a store only leaves once memory has finished the handshake
    assign retire0 = !empty && ready_q[head_q] && !halt_q[head_q]
                     && (!store_q[head_q] || store_done);

    assign retire1 = retire0 && !mispred_q[head_q] && !halt_q[head_q] && !store_q[head_q]
                     && valid_q[head_plus1] && ready_q[head_plus1]
                     && !halt_q[head_plus1] && !store_q[head_plus1];

    assign squash0   = retire0 && mispred_q[head_q];
    assign squash1   = retire1 && mispred_q[head_plus1];
    assign squash    = squash0 || squash1;
    assign squash_pc = squash0 ? target_q[head_q] : target_q[head_plus1];

    assign retire0_write = retire0 && (dest_q[head_q] != zero_reg);
    assign retire0_dest  = dest_q[head_q];
    assign retire0_value = value_q[head_q];
    assign retire1_write = retire1 && (dest_q[head_plus1] != zero_reg);
    assign retire1_dest  = dest_q[head_plus1];
    assign retire1_value = value_q[head_plus1];

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        idx_t slot;

        head_n    = head_q;
        tail_n    = tail_q;
        count_n   = count_q;
        valid_n   = valid_q;
        ready_n   = ready_q;
        mispred_n = mispred_q;
        branch_n  = branch_q;
        pred_n    = pred_q;
        store_n   = store_q;
        halt_n    = halt_q;
        pc_n      = pc_q;
        value_n   = value_q;
        target_n  = target_q;
        dest_n    = dest_q;
        slot      = '0;

        if (squash) begin
            // everything younger than the retiring branch is wrong path
            head_n    = '0;
            tail_n    = '0;
            count_n   = '0;
            valid_n   = '0;
            ready_n   = '0;
            mispred_n = '0;
        end else begin
            if (accept) begin
                valid_n[tail_q]   = 1'b1;
                ready_n[tail_q]   = dispatch_halt;
                mispred_n[tail_q] = 1'b0;
                branch_n[tail_q]  = dispatch_is_branch;
                pred_n[tail_q]    = dispatch_pred_taken;
                store_n[tail_q]   = dispatch_store;
                halt_n[tail_q]    = dispatch_halt;
                pc_n[tail_q]      = dispatch_pc;
                dest_n[tail_q]    = dispatch_dest;
                value_n[tail_q]   = '0;
                target_n[tail_q]  = '0;
                tail_n            = tail_q + 1'b1;
            end

            for (int b = 0; b < 2; b++) begin
                slot = cdb_tag[b][idx_bits-1:0];
                if (cdb_valid[b] && valid_q[slot]) begin
                    ready_n[slot]   = 1'b1;
                    value_n[slot]   = cdb_value[b];
                    // not taken resumes at the fall-through
                    target_n[slot]  = cdb_taken[b] ? cdb_target[b] : pc_q[slot] + 32'd4;
                    mispred_n[slot] = branch_q[slot] && (pred_q[slot] != cdb_taken[b]);
                end
            end

            if (retire0) begin
                valid_n[head_q] = 1'b0;
                ready_n[head_q] = 1'b0;
            end
            if (retire1) begin
                valid_n[head_plus1] = 1'b0;
                ready_n[head_plus1] = 1'b0;
            end

            head_n  = head_q + idx_t'(retire0) + idx_t'(retire1);
            count_n = count_q + count_t'(accept) - count_t'(retire0) - count_t'(retire1);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q    <= '0;
            tail_q    <= '0;
            count_q   <= '0;
            valid_q   <= '0;
            ready_q   <= '0;
            mispred_q <= '0;
        end else begin
            head_q    <= head_n;
            tail_q    <= tail_n;
            count_q   <= count_n;
            valid_q   <= valid_n;
            ready_q   <= ready_n;
            mispred_q <= mispred_n;
        end
    end

    // payload, qualified by valid
    always_ff @(posedge clock) begin
        branch_q <= branch_n;
        pred_q   <= pred_n;
        store_q  <= store_n;
        halt_q   <= halt_n;
        pc_q     <= pc_n;
        value_q  <= value_n;
        target_q <= target_n;
        dest_q   <= dest_n;
    end

endmodule

/* hw/store_commit.sv */
/*
 * store commit sequencer
 * runs one four-phase req/ack exchange with memory for the store
 * at the head and pulses store_done when it is finished
 */

`timescale 1ns/100ps

module store_commit (
    input  logic clock,
    input  logic reset,
    input  logic store_pending,
    input  logic squash,
    input  logic mem_ack,
    output logic mem_req,
    output logic store_done
);
    import rob_pkg::*;

    store_state_t state_q, state_n;

    always_comb begin
        state_n = state_q;
        case (state_q)
            idle: begin
                if (store_pending && !squash) begin
                    state_n = request;
                end
            end
            request: begin
                if (mem_ack) begin
                    state_n = wait_release;
                end
            end
            wait_release: begin
                if (!mem_ack) begin
                    state_n = done;
                end
            end
            // store leaves the buffer this cycle
            done:    state_n = idle;
            default: state_n = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= idle;
        end else begin
            state_q <= state_n;
        end
    end

    assign mem_req    = (state_q == request);
    assign store_done = (state_q == done);

endmodule

/* hw/redirect_scan.sv */
/*
 * early redirect scan
 * finds the oldest resolved mispredicted branch in the window
 */

`timescale 1ns/100ps

module redirect_scan #(
    parameter int rob_depth = 8
) (
    input  rob_pkg::rob_tag_t                    head,
    input  logic           [rob_depth-1:0]       entry_valid,
    input  logic           [rob_depth-1:0]       entry_ready,
    input  logic           [rob_depth-1:0]       entry_mispred,
    input  isa_pkg::word_t [rob_depth-1:0]       entry_target,
    output logic                                 early_redirect_valid,
    output isa_pkg::word_t                       early_redirect_pc
);
    localparam int idx_bits = $clog2(rob_depth);

    logic [idx_bits-1:0] slot;

    // youngest to oldest, so the oldest hit is written last
    always_comb begin
        early_redirect_valid = 1'b0;
        early_redirect_pc    = '0;
        slot                 = '0;
        for (int i = rob_depth - 1; i >= 0; i--) begin
            slot = head[idx_bits-1:0] + i[idx_bits-1:0];
            if (entry_valid[slot] && entry_ready[slot] && entry_mispred[slot]) begin
                early_redirect_valid = 1'b1;
                early_redirect_pc    = entry_target[slot];
            end
        end
    end

endmodule

/* hw/arch_regfile.sv */
/*
 * architectural register file
 * two retire write ports, one combinational read port
 */

`timescale 1ns/100ps

module arch_regfile #(
    parameter int reg_count = 32
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              write0_enable,
    input  isa_pkg::reg_idx_t write0_index,
    input  isa_pkg::word_t    write0_value,
    input  logic              write1_enable,
    input  isa_pkg::reg_idx_t write1_index,
    input  isa_pkg::word_t    write1_value,
    input  isa_pkg::reg_idx_t read_index,
    output isa_pkg::word_t    read_value
);
    import isa_pkg::*;

    word_t regs [reg_count];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (write0_enable && write0_index != zero_reg) begin
                regs[write0_index] <= write0_value;
            end
            if (write1_enable && write1_index != zero_reg) begin
                regs[write1_index] <= write1_value;
            end
        end
    end

    assign read_value = (read_index == zero_reg) ? '0 : regs[read_index];

endmodule

/* hw/retire_unit.sv */
/*
 * retirement side of the core
 * reorder buffer, store sequencer, redirect scan and register file
 */

`timescale 1ns/100ps

module retire_unit #(
    parameter int rob_depth = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch_valid,
    input  isa_pkg::word_t    dispatch_pc,
    input  isa_pkg::reg_idx_t dispatch_dest,
    input  logic              dispatch_is_branch,
    input  logic              dispatch_pred_taken,
    input  logic              dispatch_store,
    input  logic              dispatch_halt,
    output rob_pkg::rob_tag_t dispatch_tag,
    output logic              rob_full,
    input  logic              cdb0_valid,
    input  rob_pkg::rob_tag_t cdb0_tag,
    input  isa_pkg::word_t    cdb0_value,
    input  logic              cdb0_taken,
    input  isa_pkg::word_t    cdb0_target,
    input  logic              cdb1_valid,
    input  rob_pkg::rob_tag_t cdb1_tag,
    input  isa_pkg::word_t    cdb1_value,
    input  logic              cdb1_taken,
    input  isa_pkg::word_t    cdb1_target,
    output logic              mem_req,
    input  logic              mem_ack,
    output logic              squash,
    output isa_pkg::word_t    squash_pc,
    output logic              halt,
    output logic              early_redirect_valid,
    output isa_pkg::word_t    early_redirect_pc,
    input  isa_pkg::reg_idx_t read_index,
    output isa_pkg::word_t    read_value
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int reg_count = 32;

    rob_tag_t                   head;
    logic     [rob_depth-1:0]   entry_valid, entry_ready, entry_mispred;
    word_t    [rob_depth-1:0]   entry_target;
    logic                       store_pending, store_done;
    logic                       retire0_write, retire1_write;
    reg_idx_t                   retire0_dest, retire1_dest;
    word_t                      retire0_value, retire1_value;

    reorder_buffer #(.rob_depth(rob_depth)) reorder_buffer_i (
        .clock, .reset,
        .dispatch_valid, .dispatch_pc, .dispatch_dest, .dispatch_is_branch,
        .dispatch_pred_taken, .dispatch_store, .dispatch_halt,
        .cdb0_valid, .cdb0_tag, .cdb0_value, .cdb0_taken, .cdb0_target,
        .cdb1_valid, .cdb1_tag, .cdb1_value, .cdb1_taken, .cdb1_target,
        .store_done, .dispatch_tag, .rob_full, .head,
        .entry_valid, .entry_ready, .entry_mispred, .entry_target,
        .store_pending, .squash, .squash_pc, .halt,
        .retire0_write, .retire0_dest, .retire0_value,
        .retire1_write, .retire1_dest, .retire1_value
    );

    store_commit store_commit_i (
        .clock, .reset, .store_pending, .squash, .mem_ack, .mem_req, .store_done
    );

    redirect_scan #(.rob_depth(rob_depth)) redirect_scan_i (
        .head, .entry_valid, .entry_ready, .entry_mispred, .entry_target,
        .early_redirect_valid, .early_redirect_pc
    );

    arch_regfile #(.reg_count(reg_count)) arch_regfile_i (
        .clock, .reset,
        .write0_enable(retire0_write), .write0_index(retire0_dest),
        .write0_value(retire0_value),
        .write1_enable(retire1_write), .write1_index(retire1_dest),
        .write1_value(retire1_value),
        .read_index, .read_value
    );

endmodule

/* tests/retire_unit_tb.sv */
/*
 * testbench for the retire unit
 * drives dispatch, both result buses and the memory port, keeps a
 * reference queue of dispatched entries and an image of the registers
 */

`timescale 1ns/100ps

module retire_unit_tb;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int wait_limit  = 50;
    localparam int sel_mem_req = 0;
    localparam int sel_squash  = 1;
    localparam int sel_full    = 2;
    localparam int sel_halt    = 3;
    localparam int sel_early   = 4;

    logic     clock, reset;
    logic     dispatch_valid, dispatch_is_branch, dispatch_pred_taken;
    logic     dispatch_store, dispatch_halt;
    word_t    dispatch_pc;
    reg_idx_t dispatch_dest;
    rob_tag_t dispatch_tag;
    logic     rob_full;
    logic     cdb0_valid, cdb0_taken, cdb1_valid, cdb1_taken;
    rob_tag_t cdb0_tag, cdb1_tag;
    word_t    cdb0_value, cdb0_target, cdb1_value, cdb1_target;
    logic     mem_req, mem_ack, squash, halt, early_redirect_valid;
    word_t    squash_pc, early_redirect_pc, read_value;
    reg_idx_t read_index;

    // reference model, program order queue and register image
    reg_idx_t model_dest[$];
    word_t    model_value[$];
    word_t    exp_regs[32];
    reg_idx_t op_dest[8];
    word_t    op_value[8];
    rob_tag_t op_tag[8];

    // expected tail of the buffer
    int       next_tag     = 0;

    integer seed         = 32'h7140_cab3;
    int     error_count  = 0;
    int     test_count   = 0;
    int     failed_tests = 0;

    retire_unit #(.rob_depth(8)) retire_unit_i (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    //////////////////////////////
    // protocol checks
    //////////////////////////////

    squash_pulse: assert property (@(posedge clock) disable iff (reset)
        !(squash && $past(squash)))
    else begin
        $display("[ERROR] %0t ns: squash stayed high for more than one cycle", $time);
        error_count++;
    end

    req_held: assert property (@(posedge clock) disable iff (reset)
        !($past(mem_req) && !$past(mem_ack) && !mem_req))
    else begin
        $display("[ERROR] %0t ns: mem_req dropped before mem_ack arrived", $time);
        error_count++;
    end

    done_after_release: assert property (@(posedge clock) disable iff (reset)
        retire_unit_i.store_done |-> !$past(mem_ack))
    else begin
        $display("[ERROR] %0t ns: store_done pulsed before mem_ack was released", $time);
        error_count++;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t expected);
        assert (got === expected)
        else begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic expected);
        assert (got === expected)
        else begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, expected);
            error_count++;
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            sel_mem_req: return mem_req;
            sel_squash:  return squash;
            sel_full:    return rob_full;
            sel_halt:    return halt;
            sel_early:   return early_redirect_valid;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int sel, input logic level, input string what);
        int waited;
        waited = 0;
        while (probe(sel) !== level && waited < wait_limit) begin
            cycle();
            waited++;
        end
        if (probe(sel) !== level) begin
            abort_run(what);
        end
    endtask

    task automatic read_reg(input reg_idx_t index, output word_t value);
        read_index = index;
        #1;
        value = read_value;
    endtask

    task automatic poll_register(input reg_idx_t index, input word_t value, input string what);
        int waited;
        waited = 0;
        read_index = index;
        #1;
        while (read_value !== value && waited < wait_limit) begin
            cycle();
            #1;
            waited++;
        end
        if (read_value !== value) begin
            abort_run(what);
        end
    endtask

    task automatic verify_regs(input int n);
        word_t value;
        for (int i = 0; i < n; i++) begin
            read_reg(op_dest[i], value);
            compare_word($sformatf("read_value(x%0d)", op_dest[i]), value, exp_regs[op_dest[i]]);
        end
    endtask

    task automatic clear_buses();
        cdb0_valid = 1'b0;
        cdb1_valid = 1'b0;
    endtask

    task automatic drive_cdb(input int bus, input rob_tag_t tag, input word_t value,
                             input logic taken, input word_t target);
        if (bus == 0) begin
            cdb0_valid  = 1'b1;
            cdb0_tag    = tag;
            cdb0_value  = value;
            cdb0_taken  = taken;
            cdb0_target = target;
        end else begin
            cdb1_valid  = 1'b1;
            cdb1_tag    = tag;
            cdb1_value  = value;
            cdb1_taken  = taken;
            cdb1_target = target;
        end
    endtask

    task automatic dispatch_op(input word_t pc, input reg_idx_t dest, input word_t value,
                               input logic is_branch, input logic pred_taken,
                               input logic is_store, input logic is_halt,
                               output rob_tag_t tag);
        compare_word("dispatch_tag", 32'(dispatch_tag), 32'(next_tag));
        tag                 = rob_tag_t'(next_tag);
        dispatch_valid      = 1'b1;
        dispatch_pc         = pc;
        dispatch_dest       = dest;
        dispatch_is_branch  = is_branch;
        dispatch_pred_taken = pred_taken;
        dispatch_store      = is_store;
        dispatch_halt       = is_halt;
        cycle();
        dispatch_valid = 1'b0;
        next_tag       = (next_tag + 1) % 8;
        model_dest.push_back(dest);
        model_value.push_back(value);
    endtask

    // plain alu op with a random destination and result
    task automatic issue_alu(input int i, input logic to_zero);
        logic [31:0] r;
        r           = $random(seed);
        op_dest[i]  = to_zero ? zero_reg : reg_idx_t'(1 + r[15:0] % 31);
        op_value[i] = $random(seed);
        dispatch_op(word_t'(32'h1000 + i * 4), op_dest[i], op_value[i],
                    1'b0, 1'b0, 1'b0, 1'b0, op_tag[i]);
    endtask

    task automatic retire_model(input int n);
        reg_idx_t d;
        word_t    v;
        for (int i = 0; i < n; i++) begin
            d = model_dest.pop_front();
            v = model_value.pop_front();
            if (d != zero_reg) begin
                exp_regs[d] = v;
            end
        end
    endtask

    // a squash empties the window and restarts the tail at zero
    task automatic flush_model();
        model_dest.delete();
        model_value.delete();
        next_tag = 0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        int          start;
        int          delay;
        logic [31:0] r;
        rob_tag_t    tag;

        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_pc         = '0;
        dispatch_dest       = '0;
        dispatch_is_branch  = 1'b0;
        dispatch_pred_taken = 1'b0;
        dispatch_store      = 1'b0;
        dispatch_halt       = 1'b0;
        cdb0_valid          = 1'b0;
        cdb0_tag            = '0;
        cdb0_value          = '0;
        cdb0_taken          = 1'b0;
        cdb0_target         = '0;
        cdb1_valid          = 1'b0;
        cdb1_tag            = '0;
        cdb1_value          = '0;
        cdb1_taken          = 1'b0;
        cdb1_target         = '0;
        mem_ack             = 1'b0;
        read_index          = '0;
        foreach (exp_regs[i]) begin
            exp_regs[i] = '0;
        end
        repeat (3) @(posedge clock);
        #2;
        reset = 1'b0;

        start = error_count;
        expect_bit("rob_full", rob_full, 1'b0);
        expect_bit("squash", squash, 1'b0);
        expect_bit("halt", halt, 1'b0);
        expect_bit("mem_req", mem_req, 1'b0);
        expect_bit("store_done", retire_unit_i.store_done, 1'b0);
        expect_bit("early_redirect_valid", early_redirect_valid, 1'b0);
        report_test("reset", start);

        // six ops completed youngest first, third one targets x0
        cycle();
        start = error_count;
        for (int i = 0; i < 6; i++) begin
            issue_alu(i, i == 2);
        end
        for (int i = 5; i > 0; i -= 2) begin
            drive_cdb(0, op_tag[i], op_value[i], 1'b0, '0);
            drive_cdb(1, op_tag[i-1], op_value[i-1], 1'b0, '0);
            cycle();
            clear_buses();
        end
        retire_model(6);
        poll_register(op_dest[5], op_value[5], "in-order retirement");
        verify_regs(6);
        report_test("in_order", start);

        cycle();
        start = error_count;
        for (int i = 0; i < 8; i++) begin
            expect_bit("rob_full", rob_full, 1'b0);
            issue_alu(i, 1'b0);
        end
        expect_bit("rob_full", rob_full, 1'b1);
        // refused dispatch
        dispatch_valid = 1'b1;
        cycle();
        dispatch_valid = 1'b0;
        compare_word("dispatch_tag", 32'(dispatch_tag), 32'(next_tag));
        expect_bit("rob_full", rob_full, 1'b1);
        drive_cdb(0, op_tag[0], op_value[0], 1'b0, '0);
        cycle();
        clear_buses();
        wait_until(sel_full, 1'b0, "rob_full to fall");
        for (int i = 1; i < 8; i += 2) begin
            drive_cdb(0, op_tag[i], op_value[i], 1'b0, '0);
            if (i < 7) begin
                drive_cdb(1, op_tag[i+1], op_value[i+1], 1'b0, '0);
            end
            cycle();
            clear_buses();
        end
        retire_model(8);
        poll_register(op_dest[7], op_value[7], "drain of the full buffer");
        verify_regs(8);
        report_test("full", start);

        // branch predicted not taken resolves taken
        cycle();
        start = error_count;
        dispatch_op(32'h0000_0100, zero_reg, '0, 1'b1, 1'b0, 1'b0, 1'b0, tag);
        issue_alu(0, 1'b0);
        issue_alu(1, 1'b0);
        drive_cdb(0, op_tag[0], op_value[0], 1'b0, '0);
        drive_cdb(1, op_tag[1], op_value[1], 1'b0, '0);
        cycle();
        clear_buses();
        drive_cdb(0, tag, '0, 1'b1, 32'h0000_0200);
        cycle();
        clear_buses();
        wait_until(sel_squash, 1'b1, "squash");
        compare_word("squash_pc", squash_pc, 32'h0000_0200);
        retire_model(1);
        flush_model();
        cycle();
        expect_bit("squash", squash, 1'b0);
        compare_word("dispatch_tag", 32'(dispatch_tag), 32'd0);
        verify_regs(2);
        report_test("squash", start);

        // younger branch resolves while the head is still busy
        cycle();
        start = error_count;
        issue_alu(0, 1'b0);
        dispatch_op(32'h0000_0300, zero_reg, '0, 1'b1, 1'b0, 1'b0, 1'b0, tag);
        drive_cdb(1, tag, '0, 1'b1, 32'h0000_0480);
        cycle();
        clear_buses();
        wait_until(sel_early, 1'b1, "early redirect");
        compare_word("early_redirect_pc", early_redirect_pc, 32'h0000_0480);
        expect_bit("squash", squash, 1'b0);
        cycle();
        expect_bit("squash", squash, 1'b0);
        expect_bit("early_redirect_valid", early_redirect_valid, 1'b1);
        drive_cdb(0, op_tag[0], op_value[0], 1'b0, '0);
        cycle();
        clear_buses();
        wait_until(sel_squash, 1'b1, "squash once the head resolves");
        compare_word("squash_pc", squash_pc, 32'h0000_0480);
        retire_model(2);
        flush_model();
        poll_register(op_dest[0], op_value[0], "retirement ahead of the branch");
        verify_regs(1);
        report_test("redirect", start);

        cycle();
        start = error_count;
        dispatch_op(32'h0000_0500, zero_reg, '0, 1'b0, 1'b0, 1'b1, 1'b0, tag);
        issue_alu(0, 1'b0);
        drive_cdb(0, tag, 32'h5a5a_0000, 1'b0, '0);
        drive_cdb(1, op_tag[0], op_value[0], 1'b0, '0);
        cycle();
        clear_buses();
        wait_until(sel_mem_req, 1'b1, "mem_req to rise");
        r     = $random(seed);
        delay = 1 + int'(r[7:0] % 5);
        repeat (delay) begin
            expect_bit("mem_req", mem_req, 1'b1);
            cycle();
        end
        mem_ack = 1'b1;
        wait_until(sel_mem_req, 1'b0, "mem_req to fall");
        // younger op still held back by the store
        verify_regs(1);
        cycle();
        verify_regs(1);
        mem_ack = 1'b0;
        retire_model(2);
        poll_register(op_dest[0], op_value[0], "retirement after the store");
        verify_regs(1);
        report_test("store", start);

        cycle();
        start = error_count;
        dispatch_op(32'h0000_0600, zero_reg, '0, 1'b0, 1'b0, 1'b0, 1'b1, tag);
        issue_alu(0, 1'b0);
        wait_until(sel_halt, 1'b1, "halt");
        drive_cdb(0, op_tag[0], op_value[0], 1'b0, '0);
        cycle();
        clear_buses();
        repeat (8) begin
            expect_bit("halt", halt, 1'b1);
            verify_regs(1);
            cycle();
        end
        report_test("halt", start);

        $display("tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* build.f */
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/reorder_buffer.sv
hw/store_commit.sv
hw/redirect_scan.sv
hw/arch_regfile.sv
hw/retire_unit.sv
tests/retire_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the retire unit testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -f build.f \
    --top-module retire_unit_tb -Mdir obj_dir \
    && ./obj_dir/Vretire_unit_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
